/* design/calc_pkg.sv */
//**************************************************************************
// Execute calculator package
// Word and register widths, the opcode set and the fixed commit depth
// shared by the calculator pipeline
//**************************************************************************

`default_nettype none

package calc_pkg;

  localparam int word_width_lp = 32;
  localparam int reg_count_lp  = 32;

  // Edges from issue sample to the cycle with commit_v_o high
  localparam int commit_depth_lp = 3;

  typedef logic [$clog2(reg_count_lp)-1:0] reg_addr_t;
  typedef logic [word_width_lp-1:0]        word_t;

  typedef enum logic [2:0]
  {
    OP_ADD = 3'd0
  , OP_SUB = 3'd1
  , OP_AND = 3'd2
  , OP_OR  = 3'd3
  , OP_XOR = 3'd4
  , OP_SLL = 3'd5
  , OP_LI  = 3'd6
  , OP_MUL = 3'd7
  } calc_op_e;

endpackage

`default_nettype wire

/* design/calc_ctrl.sv */
//**************************************************************************
// Calculator control
// Issue register, decode and the per-stage shift of write valid, rd and
// multiply flag. EX1 poison kills the entry before it can forward or commit
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module calc_ctrl
  import calc_pkg::*;
  (
    input  logic      clk_i
  , input  logic      reset_i
  , input  logic      issue_v_i
  , input  calc_op_e  issue_op_i
  , input  reg_addr_t issue_rd_i
  , input  reg_addr_t issue_rs1_i
  , input  reg_addr_t issue_rs2_i
  , input  logic      poison_ex1_i
  , output reg_addr_t isd_rs1_o
  , output reg_addr_t isd_rs2_o
  , output calc_op_e  ex1_op_o
  , output logic      ex1_int_v_o
  , output reg_addr_t ex1_rd_o
  , output logic      ex2_wb_v_o
  , output reg_addr_t ex2_rd_o
  , output logic      mul_sel_o
  , output logic      wb_v_o
  , output reg_addr_t wb_rd_o
  );

  logic      isd_v_r;
  calc_op_e  isd_op_r;
  reg_addr_t isd_rd_r;
  reg_addr_t isd_rs1_r;
  reg_addr_t isd_rs2_r;

  logic      ex1_wr_r;
  logic      ex1_mul_r;
  reg_addr_t ex1_rd_r;
  logic      ex2_wb_r;
  logic      ex2_mul_r;
  reg_addr_t ex2_rd_r;
  logic      wb_v_r;
  reg_addr_t wb_rd_r;

  logic isd_wr;
  logic isd_mul;
  logic ex1_live;

  // Decode in ISD, writes to x0 never count as writers
  assign isd_wr  = isd_v_r & (isd_rd_r != '0);
  assign isd_mul = isd_v_r & (isd_op_r == OP_MUL);

  // Poison drops the EX1 writer in the same cycle
  assign ex1_live = ex1_wr_r & ~poison_ex1_i;

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          isd_v_r   <= 1'b0;
          ex1_wr_r  <= 1'b0;
          ex1_mul_r <= 1'b0;
          ex2_wb_r  <= 1'b0;
          ex2_mul_r <= 1'b0;
          wb_v_r    <= 1'b0;
        end
      else
        begin
          isd_v_r   <= issue_v_i;
          ex1_wr_r  <= isd_wr;
          ex1_mul_r <= isd_mul;
          ex2_wb_r  <= ex1_live;
          ex2_mul_r <= ex1_mul_r;
          wb_v_r    <= ex2_wb_r;
        end
    end

  // Instruction fields and stage rd
  always_ff @(posedge clk_i)
    begin
      if (issue_v_i)
        begin
          isd_op_r  <= issue_op_i;
          isd_rd_r  <= issue_rd_i;
          isd_rs1_r <= issue_rs1_i;
          isd_rs2_r <= issue_rs2_i;
        end
      ex1_rd_r <= isd_rd_r;
      ex2_rd_r <= ex1_rd_r;
      wb_rd_r  <= ex2_rd_r;
    end

  assign isd_rs1_o = isd_rs1_r;
  assign isd_rs2_o = isd_rs2_r;

  // Opcode handed to the dispatch register at E1
  assign ex1_op_o = isd_op_r;

  // A MUL result only exists from the EX2 merge on
  assign ex1_int_v_o = ex1_live & ~ex1_mul_r;
  assign ex1_rd_o    = ex1_rd_r;
  assign ex2_wb_v_o  = ex2_wb_r;
  assign ex2_rd_o    = ex2_rd_r;
  assign mul_sel_o   = ex2_mul_r;
  assign wb_v_o      = wb_v_r;
  assign wb_rd_o     = wb_rd_r;

endmodule

`default_nettype wire

/* design/int_regfile.sv */
//**************************************************************************
// Integer register file
// 32 x 32-bit, two combinational write-first read ports, one write port,
// x0 reads as zero
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module int_regfile
  import calc_pkg::*;
  (
    input  logic      clk_i
  , input  logic      reset_i
  , input  reg_addr_t rs1_addr_i
  , input  reg_addr_t rs2_addr_i
  , input  logic      wr_v_i
  , input  reg_addr_t wr_addr_i
  , input  word_t     wr_data_i
  , output word_t     rs1_data_o
  , output word_t     rs2_data_o
  );

  word_t rf_r [reg_count_lp];

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          for (int i = 0; i < reg_count_lp; i++)
            rf_r[i] <= '0;
        end
      else if (wr_v_i && (wr_addr_i != '0))
        rf_r[wr_addr_i] <= wr_data_i;
    end

  // Same-cycle write wins over the stored value
  function automatic word_t read_port(input reg_addr_t addr);
    if (addr == '0)
      return '0;
    else if (wr_v_i && (wr_addr_i == addr))
      return wr_data_i;
    else
      return rf_r[addr];
  endfunction

  always_comb
    begin
      rs1_data_o = read_port(rs1_addr_i);
      rs2_data_o = read_port(rs2_addr_i);
    end

endmodule

`default_nettype wire

/* design/operand_bypass.sv */
//**************************************************************************
// Operand bypass
// Picks the youngest in-flight result matching each source register,
// falling back to the register file data
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module operand_bypass
  import calc_pkg::*;
  (
    input  reg_addr_t rs1_addr_i
  , input  reg_addr_t rs2_addr_i
  , input  word_t     rf_rs1_i
  , input  word_t     rf_rs2_i
  , input  logic      ex1_v_i
  , input  reg_addr_t ex1_rd_i
  , input  word_t     ex1_data_i
  , input  logic      ex2_v_i
  , input  reg_addr_t ex2_rd_i
  , input  word_t     ex2_data_i
  , input  logic      wb_v_i
  , input  reg_addr_t wb_rd_i
  , input  word_t     wb_data_i
  , output word_t     rs1_o
  , output word_t     rs2_o
  );

  // Valids are already clear for x0 and poisoned entries
  function automatic word_t pick(input reg_addr_t addr, input word_t rf_data);
    if (ex1_v_i && (ex1_rd_i == addr))
      return ex1_data_i;
    else if (ex2_v_i && (ex2_rd_i == addr))
      return ex2_data_i;
    else if (wb_v_i && (wb_rd_i == addr))
      return wb_data_i;
    else
      return rf_data;
  endfunction

  always_comb
    begin
      rs1_o = pick(rs1_addr_i, rf_rs1_i);
      rs2_o = pick(rs2_addr_i, rf_rs2_i);
    end

endmodule

`default_nettype wire

/* design/pipe_int.sv */
//**************************************************************************
// Integer pipe
// Dispatch register for operands, opcode and immediate, with the
// one-cycle ALU evaluated in EX1
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module pipe_int
  import calc_pkg::*;
  (
    input  logic     clk_i
  , input  logic     reset_i
  , input  calc_op_e issue_op_i
  , input  word_t    issue_imm_i
  , input  word_t    rs1_i
  , input  word_t    rs2_i
  , input  logic     dispatch_v_i
  , output word_t    data_o
  , output word_t    opnd_a_o
  , output word_t    opnd_b_o
  , output calc_op_e op_o
  );

  word_t    imm_isd_r;
  calc_op_e op_r;
  word_t    a_r;
  word_t    b_r;
  word_t    imm_r;

  // Immediate rides alongside the issue register through ISD
  always_ff @(posedge clk_i)
    begin
      if (dispatch_v_i)
        imm_isd_r <= issue_imm_i;
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          op_r  <= OP_ADD;
          a_r   <= '0;
          b_r   <= '0;
          imm_r <= '0;
        end
      else
        begin
          op_r  <= issue_op_i;
          a_r   <= rs1_i;
          b_r   <= rs2_i;
          imm_r <= imm_isd_r;
        end
    end

  always_comb
    begin
      case (op_r)
        OP_ADD:  data_o = a_r + b_r;
        OP_SUB:  data_o = a_r - b_r;
        OP_AND:  data_o = a_r & b_r;
        OP_OR:   data_o = a_r | b_r;
        OP_XOR:  data_o = a_r ^ b_r;
        OP_SLL:  data_o = a_r << b_r[4:0];
        OP_LI:   data_o = imm_r;
        // MUL leaves zero in EX2, the product merges later
        default: data_o = '0;
      endcase
    end

  assign opnd_a_o = a_r;
  assign opnd_b_o = b_r;
  assign op_o     = op_r;

endmodule

`default_nettype wire

/* design/pipe_mul.sv */
//**************************************************************************
// Multiply pipe
// Operands captured at the end of EX1, low 32 bits of the product formed
// during EX2 and taken into the commit register at the next edge
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module pipe_mul
  import calc_pkg::*;
  (
    input  logic     clk_i
  , input  calc_op_e op_i
  , input  word_t    a_i
  , input  word_t    b_i
  , output word_t    data_o
  );

  word_t a_r;
  word_t b_r;

  // Only a MUL in EX1 toggles the multiplier inputs
  always_ff @(posedge clk_i)
    begin
      if (op_i == OP_MUL)
        begin
          a_r <= a_i;
          b_r <= b_i;
        end
    end

  // Low half of the product
  assign data_o = a_r * b_r;

endmodule

`default_nettype wire

/* design/completion_pipe.sv */
//**************************************************************************
// Completion pipe
// EX2 and commit result registers, merging the multiply result at the
// EX2 to commit boundary and supplying forwarding values
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module completion_pipe
  import calc_pkg::*;
  (
    input  logic  clk_i
  , input  logic  reset_i
  , input  word_t int_data_i
  , input  word_t mul_data_i
  , input  logic  mul_sel_i
  , output word_t ex2_next_o
  , output word_t wb_data_o
  );

  word_t ex2_r;
  word_t wb_r;

  // Commit input, also the EX2 forwarding value
  assign ex2_next_o = mul_sel_i ? mul_data_i : ex2_r;

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          ex2_r <= '0;
          wb_r  <= '0;
        end
      else
        begin
          ex2_r <= int_data_i;
          wb_r  <= ex2_next_o;
        end
    end

  assign wb_data_o = wb_r;

endmodule

`default_nettype wire

/* design/calc_top.sv */
//**************************************************************************
// Execute calculator top
// Issue register, register file, bypass, integer and multiply pipes and
// the completion pipe, committing every result at a fixed depth
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module calc_top
  import calc_pkg::*;
  (
    input  logic      clk_i
  , input  logic      reset_i
  , input  logic      issue_v_i
  , input  calc_op_e  issue_op_i
  , input  reg_addr_t issue_rd_i
  , input  reg_addr_t issue_rs1_i
  , input  reg_addr_t issue_rs2_i
  , input  word_t     issue_imm_i
  , input  logic      poison_ex1_i
  , output logic      commit_v_o
  , output reg_addr_t commit_rd_o
  , output word_t     commit_data_o
  );

  reg_addr_t isd_rs1;
  reg_addr_t isd_rs2;
  calc_op_e  dispatch_op;
  logic      ex1_int_v;
  reg_addr_t ex1_rd;
  logic      ex2_wb_v;
  reg_addr_t ex2_rd;
  logic      mul_sel;
  word_t     rf_rs1;
  word_t     rf_rs2;
  word_t     byp_rs1;
  word_t     byp_rs2;
  word_t     int_data;
  word_t     opnd_a;
  word_t     opnd_b;
  calc_op_e  ex1_op;
  word_t     mul_data;
  word_t     ex2_next;

  calc_ctrl ctrl_inst
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.issue_v_i(issue_v_i)
    ,.issue_op_i(issue_op_i)
    ,.issue_rd_i(issue_rd_i)
    ,.issue_rs1_i(issue_rs1_i)
    ,.issue_rs2_i(issue_rs2_i)
    ,.poison_ex1_i(poison_ex1_i)
    ,.isd_rs1_o(isd_rs1)
    ,.isd_rs2_o(isd_rs2)
    ,.ex1_op_o(dispatch_op)
    ,.ex1_int_v_o(ex1_int_v)
    ,.ex1_rd_o(ex1_rd)
    ,.ex2_wb_v_o(ex2_wb_v)
    ,.ex2_rd_o(ex2_rd)
    ,.mul_sel_o(mul_sel)
    ,.wb_v_o(commit_v_o)
    ,.wb_rd_o(commit_rd_o)
    );

  // Commit stage writes back at the end of the commit cycle
  int_regfile regfile_inst
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.rs1_addr_i(isd_rs1)
    ,.rs2_addr_i(isd_rs2)
    ,.wr_v_i(commit_v_o)
    ,.wr_addr_i(commit_rd_o)
    ,.wr_data_i(commit_data_o)
    ,.rs1_data_o(rf_rs1)
    ,.rs2_data_o(rf_rs2)
    );

  operand_bypass bypass_inst
    (.rs1_addr_i(isd_rs1)
    ,.rs2_addr_i(isd_rs2)
    ,.rf_rs1_i(rf_rs1)
    ,.rf_rs2_i(rf_rs2)
    ,.ex1_v_i(ex1_int_v)
    ,.ex1_rd_i(ex1_rd)
    ,.ex1_data_i(int_data)
    ,.ex2_v_i(ex2_wb_v)
    ,.ex2_rd_i(ex2_rd)
    ,.ex2_data_i(ex2_next)
    ,.wb_v_i(commit_v_o)
    ,.wb_rd_i(commit_rd_o)
    ,.wb_data_i(commit_data_o)
    ,.rs1_o(byp_rs1)
    ,.rs2_o(byp_rs2)
    );

  // Issue strobe captures the immediate next to the issue register
  pipe_int pipe_int_inst
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.issue_op_i(dispatch_op)
    ,.issue_imm_i(issue_imm_i)
    ,.rs1_i(byp_rs1)
    ,.rs2_i(byp_rs2)
    ,.dispatch_v_i(issue_v_i)
    ,.data_o(int_data)
    ,.opnd_a_o(opnd_a)
    ,.opnd_b_o(opnd_b)
    ,.op_o(ex1_op)
    );

  pipe_mul pipe_mul_inst
    (.clk_i(clk_i)
    ,.op_i(ex1_op)
    ,.a_i(opnd_a)
    ,.b_i(opnd_b)
    ,.data_o(mul_data)
    );

  completion_pipe completion_inst
    (.clk_i(clk_i)
    ,.reset_i(reset_i)
    ,.int_data_i(int_data)
    ,.mul_data_i(mul_data)
    ,.mul_sel_i(mul_sel)
    ,.ex2_next_o(ex2_next)
    ,.wb_data_o(commit_data_o)
    );

endmodule

`default_nettype wire

/* testbench/clk_gen.sv */
//**************************************************************************
// Testbench clock
// Free-running 20 ns clock for the calculator testbench
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module clk_gen
  (
    output logic clk_o
  );

  initial
    begin
      clk_o = 1'b0;
      forever #10 clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

/* testbench/calc_tb.sv */
//**************************************************************************
// Execute calculator testbench
// Directed and random instruction streams against a register model, with
// every commit checked for valid, rd, data and exact commit depth
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module calc_tb
  import calc_pkg::*;
  ();

  typedef struct packed {
    logic        present;
    reg_addr_t   rd;
    word_t       data;
    logic [31:0] due;
  } commit_exp_t;

  localparam int drain_limit = 50;

  logic      clk;
  logic      reset;
  logic      issue_v;
  calc_op_e  issue_op;
  reg_addr_t issue_rd;
  reg_addr_t issue_rs1;
  reg_addr_t issue_rs2;
  word_t     issue_imm;
  logic      poison_ex1;
  logic      commit_v;
  reg_addr_t commit_rd;
  word_t     commit_data;

  word_t       model_rf [reg_count_lp];
  commit_exp_t exp_q [$];
  commit_exp_t exp_now;
  logic [31:0] edge_cnt = '0;
  integer      seed;
  logic [1:0]  poison_q = 2'b00;
  logic        last_mul = 1'b0;
  reg_addr_t   last_mul_rd = '0;
  int          wait_cycles;

  clk_gen clk_gen_inst (.clk_o(clk));

  calc_top calc_top_inst
    (.clk_i(clk)
    ,.reset_i(reset)
    ,.issue_v_i(issue_v)
    ,.issue_op_i(issue_op)
    ,.issue_rd_i(issue_rd)
    ,.issue_rs1_i(issue_rs1)
    ,.issue_rs2_i(issue_rs2)
    ,.issue_imm_i(issue_imm)
    ,.poison_ex1_i(poison_ex1)
    ,.commit_v_o(commit_v)
    ,.commit_rd_o(commit_rd)
    ,.commit_data_o(commit_data)
    );

  always @(posedge clk)
    edge_cnt <= edge_cnt + 1;

  // Architectural result of one instruction
  function automatic word_t expected_result(input calc_op_e op, input word_t a,
                                            input word_t b, input word_t imm);
    logic [63:0] prod;
    word_t       r;
    prod = {32'b0, a} * {32'b0, b};
    case (op)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      OP_SLL:  r = a << b[4:0];
      OP_LI:   r = imm;
      default: r = prod[31:0];
    endcase
    return r;
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("TEST FAIL");
  endtask

  // One issue slot that also drives the EX1 poison of the instruction two slots back
  task automatic drive_slot(input logic v, input calc_op_e op, input reg_addr_t rd,
                            input reg_addr_t rs1, input reg_addr_t rs2,
                            input word_t imm, input logic poison);
    commit_exp_t e;
    @(posedge clk);
    issue_v    <= v;
    issue_op   <= op;
    issue_rd   <= rd;
    issue_rs1  <= rs1;
    issue_rs2  <= rs2;
    issue_imm  <= imm;
    poison_ex1 <= poison_q[1];
    poison_q = {poison_q[0], v & poison};
    if (v)
      begin
        e.present = !poison && (rd != '0);
        e.rd      = rd;
        e.data    = expected_result(op, model_rf[rs1], model_rf[rs2], imm);
        e.due     = edge_cnt + 2 + commit_depth_lp;
        exp_q.push_back(e);
        if (e.present)
          model_rf[rd] = e.data;
      end
    last_mul    = v && (op == OP_MUL);
    last_mul_rd = rd;
  endtask

  task automatic idle_cycles(input int count);
    for (int i = 0; i < count; i++)
      drive_slot(1'b0, OP_ADD, '0, '0, '0, '0, 1'b0);
  endtask

  // Negative op_sel picks a random opcode per instruction
  task automatic random_burst(input int count, input int op_sel, input logic allow_poison);
    logic [31:0] r;
    calc_op_e    op;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    word_t       imm;
    logic        poison;
    for (int i = 0; i < count; i++)
      begin
        r      = $random(seed);
        imm    = $random(seed);
        op     = (op_sel < 0) ? calc_op_e'(r[2:0]) : calc_op_e'(op_sel[2:0]);
        rd     = r[7:3];
        rs1    = r[12:8];
        rs2    = r[17:13];
        poison = allow_poison && (r[20:18] == 3'd0);
        // No read of a MUL destination in the very next slot
        if (last_mul && (rs1 == last_mul_rd))
          rs1 = rs1 + 5'd1;
        if (last_mul && (rs2 == last_mul_rd))
          rs2 = rs2 + 5'd1;
        drive_slot(1'b1, op, rd, rs1, rs2, imm, poison);
      end
  endtask

  // Commit checker with one expected slot per issued instruction
  always @(negedge clk)
    begin
      if (!reset)
        begin
          if ((exp_q.size() != 0) && (exp_q[0].due == edge_cnt))
            begin
              exp_now = exp_q.pop_front();
              assert (commit_v === exp_now.present)
                else
                  begin
                    report_error($sformatf("commit_v_o is %b, expected %b for x%0d",
                                           commit_v, exp_now.present, exp_now.rd));
                    $fatal(1, "commit valid mismatch");
                  end
              if (exp_now.present)
                begin
                  assert ((commit_rd === exp_now.rd) && (commit_data === exp_now.data))
                    else
                      begin
                        report_error($sformatf("commit x%0d = %h, expected x%0d = %h",
                                               commit_rd, commit_data,
                                               exp_now.rd, exp_now.data));
                        $fatal(1, "commit result mismatch");
                      end
                end
            end
          else
            begin
              assert (commit_v === 1'b0)
                else
                  begin
                    report_error($sformatf("unexpected commit to x%0d", commit_rd));
                    $fatal(1, "unexpected commit");
                  end
            end
        end
    end

  initial
    begin
      seed = 32'h44df_a917;
      for (int k = 0; k < reg_count_lp; k++)
        model_rf[k] = '0;
      reset      <= 1'b1;
      issue_v    <= 1'b0;
      issue_op   <= OP_ADD;
      issue_rd   <= '0;
      issue_rs1  <= '0;
      issue_rs2  <= '0;
      issue_imm  <= '0;
      poison_ex1 <= 1'b0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;

      // Quiet after reset before every register is read as zero
      idle_cycles(6);
      for (int k = 0; k < reg_count_lp; k++)
        drive_slot(1'b1, OP_ADD, reg_addr_t'(k), reg_addr_t'(k), '0, '0, 1'b0);

      // Load all registers and run each opcode on random operands
      for (int k = 1; k < reg_count_lp; k++)
        drive_slot(1'b1, OP_LI, reg_addr_t'(k), '0, '0, $random(seed), 1'b0);
      for (int op = 0; op < 8; op++)
        random_burst(8, op, 1'b0);
      random_burst(150, -1, 1'b0);

      // Dependent pairs at distances 1 to 4
      // A nonzero x7 makes every producer change x5
      drive_slot(1'b1, OP_LI, 5'd7, '0, '0, 32'h0000_0101, 1'b0);
      for (int d = 1; d <= 4; d++)
        begin
          drive_slot(1'b1, OP_ADD, 5'd5, 5'd5, 5'd7, '0, 1'b0);
          for (int f = 1; f < d; f++)
            drive_slot(1'b1, OP_XOR, reg_addr_t'(20 + f), 5'd1, 5'd2, '0, 1'b0);
          drive_slot(1'b1, OP_ADD, 5'd6, 5'd5, 5'd5, '0, 1'b0);
        end

      // MUL results read two slots later
      drive_slot(1'b1, OP_MUL, 5'd9, 5'd1, 5'd2, '0, 1'b0);
      drive_slot(1'b1, OP_XOR, 5'd10, 5'd3, 5'd4, '0, 1'b0);
      drive_slot(1'b1, OP_ADD, 5'd11, 5'd9, 5'd0, '0, 1'b0);
      drive_slot(1'b1, OP_MUL, 5'd12, 5'd9, 5'd9, '0, 1'b0);
      idle_cycles(1);
      drive_slot(1'b1, OP_MUL, 5'd13, 5'd12, 5'd12, '0, 1'b0);
      idle_cycles(1);
      drive_slot(1'b1, OP_OR, 5'd14, 5'd13, 5'd12, '0, 1'b0);

      // Poisoned writers leave the older value visible
      drive_slot(1'b1, OP_LI, 5'd15, '0, '0, 32'h1234_5678, 1'b0);
      drive_slot(1'b1, OP_ADD, 5'd15, 5'd15, 5'd15, '0, 1'b1);
      drive_slot(1'b1, OP_ADD, 5'd16, 5'd15, 5'd0, '0, 1'b0);
      drive_slot(1'b1, OP_OR, 5'd17, 5'd0, 5'd15, '0, 1'b0);
      drive_slot(1'b1, OP_XOR, 5'd18, 5'd15, 5'd15, '0, 1'b0);
      drive_slot(1'b1, OP_MUL, 5'd19, 5'd15, 5'd15, '0, 1'b1);
      idle_cycles(1);
      drive_slot(1'b1, OP_ADD, 5'd20, 5'd19, 5'd0, '0, 1'b0);
      random_burst(200, -1, 1'b1);

      // Writes to x0 never commit
      drive_slot(1'b1, OP_LI, 5'd0, '0, '0, 32'hdead_beef, 1'b0);
      drive_slot(1'b1, OP_ADD, 5'd0, 5'd1, 5'd2, '0, 1'b0);
      drive_slot(1'b1, OP_MUL, 5'd0, 5'd3, 5'd4, '0, 1'b0);
      idle_cycles(1);
      drive_slot(1'b1, OP_ADD, 5'd21, 5'd0, 5'd0, '0, 1'b0);
      drive_slot(1'b1, OP_OR, 5'd22, 5'd0, 5'd1, '0, 1'b0);

      wait_cycles = 0;
      while ((exp_q.size() != 0) && (wait_cycles < drain_limit))
        begin
          idle_cycles(1);
          wait_cycles++;
        end
      idle_cycles(4);
      if (exp_q.size() == 0)
        begin
          $display("TEST PASS");
          $finish;
        end
      else
        begin
          $display("Commits stopped with %0d results still expected", exp_q.size());
          $display("TEST FAIL");
          $fatal(1, "drain timeout");
        end
    end

endmodule

`default_nettype wire

/* sim.f */
design/calc_pkg.sv
design/calc_ctrl.sv
design/int_regfile.sv
design/operand_bypass.sv
design/pipe_int.sv
design/pipe_mul.sv
design/completion_pipe.sv
design/calc_top.sv
testbench/clk_gen.sv
testbench/calc_tb.sv

/* Makefile */
# Verilator simulation of the execute calculator

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module calc_tb -f sim.f -o calc_sim
	./obj_dir/calc_sim | awk '{ print } /TEST PASS/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
